//--- compile.f
hw/cache_pkg.sv
hw/cache_issue.sv
hw/cache_tags.sv
hw/cache_data.sv
hw/cache_mshr.sv
hw/cache_bank.sv
verif/cache_bank_tb.sv

//--- hw/cache_bank.sv
`timescale 1ns/1ps

module cache_bank #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 core_req,
    input  cache_pkg::core_req_t core_data,
    input  logic                 mem_fill,
    input  cache_pkg::line_t     mem_fill_data,
    output logic                 core_busy,
    output logic                 core_rsp,
    output cache_pkg::word_t     core_rsp_data,
    output logic                 mem_req,
    output cache_pkg::addr_t     mem_req_addr,
    output logic                 mem_wr,
    output cache_pkg::mem_wr_t   mem_wr_data
);

    cache_pkg::bank_op_t stage_op;
    logic                hit;
    logic [NUM_WAYS-1:0] hit_way;
    logic [NUM_WAYS-1:0] fill_way;
    cache_pkg::word_t    rd_word;

    logic                fill_pending;
    logic                fill_taken;
    cache_pkg::line_t    fill_line;
    cache_pkg::addr_t    fill_addr;
    logic                replay_pending;
    logic                replay_taken;
    cache_pkg::addr_t    replay_addr;

    logic                rsp_q;
    logic                miss_q;
    cache_pkg::addr_t    miss_addr_q;

    cache_issue u_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req       (core_req),
        .core_data      (core_data),
        .fill_pending   (fill_pending),
        .fill_line      (fill_line),
        .fill_addr      (fill_addr),
        .replay_pending (replay_pending),
        .replay_addr    (replay_addr),
        .miss           (miss_q),
        .stage_op       (stage_op),
        .fill_taken     (fill_taken),
        .replay_taken   (replay_taken),
        .core_busy      (core_busy)
    );

    cache_tags #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_tags (
        .clk      (clk),
        .rst_n    (rst_n),
        .stage_op (stage_op),
        .hit      (hit),
        .hit_way  (hit_way),
        .fill_way (fill_way)
    );

    cache_data #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_data (
        .clk      (clk),
        .stage_op (stage_op),
        .hit      (hit),
        .hit_way  (hit_way),
        .fill_way (fill_way),
        .rd_word  (rd_word)
    );

    cache_mshr u_mshr (
        .clk            (clk),
        .rst_n          (rst_n),
        .miss           (miss_q),
        .miss_addr      (miss_addr_q),
        .mem_fill       (mem_fill),
        .mem_fill_data  (mem_fill_data),
        .fill_taken     (fill_taken),
        .replay_taken   (replay_taken),
        .mem_req        (mem_req),
        .mem_req_addr   (mem_req_addr),
        .fill_pending   (fill_pending),
        .fill_line      (fill_line),
        .fill_addr      (fill_addr),
        .replay_pending (replay_pending),
        .replay_addr    (replay_addr)
    );

    // Stage 2 response and miss strobes from the lookup result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_q  <= 1'b0;
            miss_q <= 1'b0;
        end else begin
            rsp_q  <= (stage_op.kind == cache_pkg::OP_READ) && hit;
            miss_q <= (stage_op.kind == cache_pkg::OP_READ) && !hit;
        end
    end

    always_ff @(posedge clk) begin
        miss_addr_q <= stage_op.addr;
    end

    assign core_rsp      = rsp_q;
    assign core_rsp_data = rd_word;

    // Write-through leaves in the lookup cycle whether the write hits or not
    assign mem_wr             = stage_op.kind == cache_pkg::OP_WRITE;
    assign mem_wr_data.addr   = stage_op.addr;
    assign mem_wr_data.byteen = stage_op.byteen;
    assign mem_wr_data.data   = stage_op.wdata;

endmodule

//--- hw/cache_data.sv
`timescale 1ns/1ps

module cache_data #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 2
) (
    input  logic                 clk,
    input  cache_pkg::bank_op_t  stage_op,
    input  logic                 hit,
    input  logic [NUM_WAYS-1:0]  hit_way,
    input  logic [NUM_WAYS-1:0]  fill_way,
    output cache_pkg::word_t     rd_word
);

    localparam int SET_BITS = $clog2(NUM_SETS);

    logic [SET_BITS-1:0]   set;
    cache_pkg::word_sel_t  word;
    logic                  fill_en;
    logic                  write_en;

    cache_pkg::line_t      way_line [NUM_WAYS];
    cache_pkg::line_t      rd_line;
    logic [NUM_WAYS-1:0]   way_q;
    cache_pkg::word_sel_t  word_q;

    assign set      = stage_op.addr[cache_pkg::LINE_OFF_BITS +: SET_BITS];
    assign word     = cache_pkg::word_sel(stage_op.addr);
    assign fill_en  = stage_op.kind == cache_pkg::OP_FILL;
    assign write_en = (stage_op.kind == cache_pkg::OP_WRITE) && hit;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_pkg::line_t mem [NUM_SETS];
        cache_pkg::line_t rd_q;

        always_ff @(posedge clk) begin
            if (fill_en && fill_way[w]) begin
                mem[set] <= stage_op.line;
            end else if (write_en && hit_way[w]) begin
                for (int b = 0; b < cache_pkg::BYTES_PER_WORD; b++) begin
                    if (stage_op.byteen[b]) begin
                        mem[set][word][8*b +: 8] <= stage_op.wdata[8*b +: 8];
                    end
                end
            end
            // Read before write on the same set
            rd_q <= mem[set];
        end

        assign way_line[w] = rd_q;
    end

    // Way and word select follow the array read by one cycle
    always_ff @(posedge clk) begin
        way_q  <= hit_way;
        word_q <= word;
    end

    always_comb begin
        rd_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_q[w]) begin
                rd_line = rd_line | way_line[w];
            end
        end
    end

    assign rd_word = rd_line[word_q];

endmodule

//--- hw/cache_issue.sv
`timescale 1ns/1ps

module cache_issue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 core_req,
    input  cache_pkg::core_req_t core_data,
    input  logic                 fill_pending,
    input  cache_pkg::line_t     fill_line,
    input  cache_pkg::addr_t     fill_addr,
    input  logic                 replay_pending,
    input  cache_pkg::addr_t     replay_addr,
    input  logic                 miss,
    output cache_pkg::bank_op_t  stage_op,
    output logic                 fill_taken,
    output logic                 replay_taken,
    output logic                 core_busy
);

    cache_pkg::bank_op_t next_op;
    logic                core_taken;
    logic                stage2_busy;
    logic                mshr_busy;

    // Fill beats replay, replay beats core
    assign fill_taken   = fill_pending;
    assign replay_taken = replay_pending && !fill_pending;
    assign core_taken   = core_req && !fill_pending && !replay_pending;

    always_comb begin
        next_op = '0;
        next_op.kind = cache_pkg::OP_NONE;
        if (fill_taken) begin
            next_op.kind = cache_pkg::OP_FILL;
            next_op.addr = fill_addr;
            next_op.line = fill_line;
        end else if (replay_taken) begin
            next_op.kind = cache_pkg::OP_READ;
            next_op.addr = replay_addr;
        end else if (core_taken) begin
            next_op.kind   = core_data.write ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
            next_op.addr   = core_data.addr;
            next_op.byteen = core_data.byteen;
            next_op.wdata  = core_data.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_op.kind <= cache_pkg::OP_NONE;
        end else begin
            stage_op <= next_op;
        end
    end

    // Busy spans both stages and the whole miss, up to the replay issue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage2_busy <= 1'b0;
            mshr_busy   <= 1'b0;
        end else begin
            stage2_busy <= stage_op.kind != cache_pkg::OP_NONE;
            if (miss) begin
                mshr_busy <= 1'b1;
            end else if (replay_taken) begin
                mshr_busy <= 1'b0;
            end
        end
    end

    assign core_busy = (stage_op.kind != cache_pkg::OP_NONE) || stage2_busy || mshr_busy;

    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) core_req |-> !core_busy
    ) else $error("core request accepted while busy");

    a_taken_during_miss: assert property (
        @(posedge clk) disable iff (!rst_n) (fill_taken || replay_taken) |-> mshr_busy
    ) else $error("fill or replay taken with no miss outstanding");

endmodule

//--- hw/cache_mshr.sv
`timescale 1ns/1ps

module cache_mshr (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              miss,
    input  cache_pkg::addr_t  miss_addr,
    input  logic              mem_fill,
    input  cache_pkg::line_t  mem_fill_data,
    input  logic              fill_taken,
    input  logic              replay_taken,
    output logic              mem_req,
    output cache_pkg::addr_t  mem_req_addr,
    output logic              fill_pending,
    output cache_pkg::line_t  fill_line,
    output cache_pkg::addr_t  fill_addr,
    output logic              replay_pending,
    output cache_pkg::addr_t  replay_addr
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_FILL,
        FILL,
        REPLAY
    } state_t;

    state_t           state;
    state_t           state_next;
    cache_pkg::addr_t addr_q;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    state_next = WAIT_FILL;
                end
            end
            WAIT_FILL: begin
                if (fill_taken) begin
                    state_next = FILL;
                end
            end
            // Fill sits in the lookup stage for this cycle
            FILL: state_next = REPLAY;
            REPLAY: begin
                if (replay_taken) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && miss) begin
            addr_q <= miss_addr;
        end
    end

    assign mem_req        = (state == IDLE) && miss;
    assign mem_req_addr   = cache_pkg::line_base(miss_addr);
    // The returning line goes straight to the arbiter
    assign fill_pending   = (state == WAIT_FILL) && mem_fill;
    assign fill_line      = mem_fill_data;
    assign fill_addr      = cache_pkg::line_base(addr_q);
    assign replay_pending = state == REPLAY;
    assign replay_addr    = addr_q;

    a_fill_expected: assert property (
        @(posedge clk) disable iff (!rst_n) mem_fill |-> state == WAIT_FILL
    ) else $error("memory fill with no miss outstanding");

    a_single_miss: assert property (
        @(posedge clk) disable iff (!rst_n) miss |-> state == IDLE
    ) else $error("second miss while one is outstanding");

endmodule

//--- hw/cache_pkg.sv
package cache_pkg;

    // Word and line geometry
    localparam int ADDR_BITS      = 32;
    localparam int WORD_BITS      = 32;
    localparam int BYTES_PER_WORD = WORD_BITS / 8;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_OFF_BITS  = $clog2(BYTES_PER_WORD);
    localparam int WORD_SEL_BITS  = $clog2(WORDS_PER_LINE);
    localparam int LINE_OFF_BITS  = WORD_OFF_BITS + WORD_SEL_BITS;

    typedef logic [ADDR_BITS-1:0]       addr_t;
    typedef logic [WORD_BITS-1:0]       word_t;
    typedef logic [BYTES_PER_WORD-1:0]  byteen_t;
    typedef logic [WORD_SEL_BITS-1:0]   word_sel_t;
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE,
        OP_FILL
    } op_kind_t;

    typedef struct packed {
        logic    write;
        addr_t   addr;
        byteen_t byteen;
        word_t   wdata;
    } core_req_t;

    // One pipeline slot, shared by core ops, replays and fills
    typedef struct packed {
        op_kind_t kind;
        addr_t    addr;
        byteen_t  byteen;
        word_t    wdata;
        line_t    line;
    } bank_op_t;

    typedef struct packed {
        addr_t   addr;
        byteen_t byteen;
        word_t   data;
    } mem_wr_t;

    function automatic addr_t line_base(addr_t addr);
        return {addr[ADDR_BITS-1:LINE_OFF_BITS], {LINE_OFF_BITS{1'b0}}};
    endfunction

    function automatic word_sel_t word_sel(addr_t addr);
        return addr[WORD_OFF_BITS +: WORD_SEL_BITS];
    endfunction

endpackage

//--- hw/cache_tags.sv
`timescale 1ns/1ps

module cache_tags #(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::bank_op_t stage_op,
    output logic                hit,
    output logic [NUM_WAYS-1:0] hit_way,
    output logic [NUM_WAYS-1:0] fill_way
);

    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = cache_pkg::ADDR_BITS - cache_pkg::LINE_OFF_BITS - SET_BITS;

    logic [TAG_BITS-1:0] tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    // One-hot round-robin victim per set
    logic [NUM_WAYS-1:0] victim_q [NUM_SETS];

    logic [SET_BITS-1:0] set;
    logic [TAG_BITS-1:0] tag;
    logic                lookup;
    logic                is_fill;

    assign set     = stage_op.addr[cache_pkg::LINE_OFF_BITS +: SET_BITS];
    assign tag     = stage_op.addr[cache_pkg::LINE_OFF_BITS + SET_BITS +: TAG_BITS];
    assign lookup  = (stage_op.kind == cache_pkg::OP_READ)
                  || (stage_op.kind == cache_pkg::OP_WRITE);
    assign is_fill = stage_op.kind == cache_pkg::OP_FILL;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way[w] = lookup && valid_q[set][w] && (tag_mem[w][set] == tag);
        end
    end

    assign hit      = |hit_way;
    assign fill_way = victim_q[set];

    always_ff @(posedge clk) begin
        if (is_fill) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill_way[w]) begin
                    tag_mem[w][set] <= tag;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s]  <= '0;
                victim_q[s] <= NUM_WAYS'(1);
            end
        end else if (is_fill) begin
            valid_q[set]  <= valid_q[set] | fill_way;
            // rotate to the next way
            victim_q[set] <= (victim_q[set] << 1) | (victim_q[set] >> (NUM_WAYS - 1));
        end
    end

    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(hit_way)
    ) else $error("line present in more than one way");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the cache bank testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module cache_bank_tb --Mdir obj_dir -o cache_bank_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/cache_bank_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    echo "Result: FAIL"
    exit 1
fi

echo "Result: PASS"
exit 0

//--- verif/cache_bank_tb.sv
`timescale 1ns/1ps

module cache_bank_tb;

    localparam int    NUM_SETS          = 16;
    localparam int    NUM_WAYS          = 2;
    localparam int    CLK_HALF          = 4;
    localparam int    RESET_CYCLES      = 16;
    localparam int    IDLE_CHECK_CYCLES = 4;
    localparam int    IDLE_LIMIT        = 40;
    localparam int    READ_LIMIT        = 12;
    localparam int    MEM_DELAY         = 5;
    localparam int    LINE_BYTES        = cache_pkg::WORDS_PER_LINE * cache_pkg::BYTES_PER_WORD;
    localparam string STIM_FILE         = "verif/cache_stimulus.txt";

    localparam cache_pkg::word_t MEM_PATTERN = 32'h5a5a0000;
    localparam cache_pkg::addr_t LINE_MASK   = ~cache_pkg::addr_t'(LINE_BYTES - 1);

    typedef struct packed {
        logic [15:0]        test_no;
        logic               write;
        cache_pkg::addr_t   addr;
        cache_pkg::byteen_t byteen;
        cache_pkg::word_t   wdata;
        cache_pkg::word_t   rdata;
    } stim_t;

    logic                 clk;
    logic                 rst_n;
    logic                 core_req;
    cache_pkg::core_req_t core_data;
    logic                 mem_fill;
    cache_pkg::line_t     mem_fill_data;
    logic                 core_busy;
    logic                 core_rsp;
    cache_pkg::word_t     core_rsp_data;
    logic                 mem_req;
    cache_pkg::addr_t     mem_req_addr;
    logic                 mem_wr;
    cache_pkg::mem_wr_t   mem_wr_data;

    stim_t                stim_q[$];
    bit                   loaded;
    int                   tests;
    int                   errors;

    // Expected residency of each set as read misses fill it
    cache_pkg::addr_t     model_line [NUM_SETS][NUM_WAYS];
    bit                   model_valid [NUM_SETS][NUM_WAYS];
    int                   model_next [NUM_SETS];

    // Words written through override the fill pattern
    cache_pkg::word_t     mem_words [cache_pkg::addr_t];

    cache_bank #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_req      (core_req),
        .core_data     (core_data),
        .mem_fill      (mem_fill),
        .mem_fill_data (mem_fill_data),
        .core_busy     (core_busy),
        .core_rsp      (core_rsp),
        .core_rsp_data (core_rsp_data),
        .mem_req       (mem_req),
        .mem_req_addr  (mem_req_addr),
        .mem_wr        (mem_wr),
        .mem_wr_data   (mem_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check_word(string name, cache_pkg::word_t got, cache_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, cache_pkg::addr_t got, cache_pkg::addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_wr(string name, cache_pkg::mem_wr_t got, cache_pkg::mem_wr_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
        end
    endtask

    function automatic cache_pkg::word_t memory_word(cache_pkg::addr_t addr);
        cache_pkg::addr_t aligned;
        cache_pkg::word_t word;
        aligned = {addr[31:2], 2'b00};
        if (mem_words.exists(aligned)) begin
            word = mem_words[aligned];
        end else begin
            word = aligned ^ MEM_PATTERN;
        end
        return word;
    endfunction

    function automatic void store_write(cache_pkg::mem_wr_t wr);
        cache_pkg::addr_t aligned;
        cache_pkg::word_t word;
        aligned = {wr.addr[31:2], 2'b00};
        word = memory_word(aligned);
        for (int b = 0; b < cache_pkg::BYTES_PER_WORD; b++) begin
            if (wr.byteen[b]) begin
                word[8*b +: 8] = wr.data[8*b +: 8];
            end
        end
        mem_words[aligned] = word;
    endfunction

    // Round-robin victim per set with allocation on read misses only
    function automatic bit predict_hit(cache_pkg::addr_t addr);
        cache_pkg::addr_t base;
        int               set_idx;
        bit               found;
        base    = addr & LINE_MASK;
        set_idx = int'((addr / LINE_BYTES) % NUM_SETS);
        found   = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[set_idx][w] && model_line[set_idx][w] == base) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            model_line[set_idx][model_next[set_idx]]  = base;
            model_valid[set_idx][model_next[set_idx]] = 1'b1;
            model_next[set_idx] = (model_next[set_idx] + 1) % NUM_WAYS;
        end
        return found;
    endfunction

    // Memory answers each line request after a fixed delay
    initial begin
        int               fill_count;
        cache_pkg::addr_t fill_base;
        cache_pkg::line_t line;
        mem_fill      <= 1'b0;
        mem_fill_data <= '0;
        fill_count = 0;
        fill_base  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_wr) begin
                store_write(mem_wr_data);
            end
            if (rst_n && mem_req) begin
                fill_base  = mem_req_addr;
                fill_count = MEM_DELAY;
            end
            @(posedge clk);
            mem_fill <= 1'b0;
            if (fill_count > 0) begin
                fill_count = fill_count - 1;
                if (fill_count == 0) begin
                    for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
                        line[w] = memory_word(fill_base + 4 * w);
                    end
                    mem_fill      <= 1'b1;
                    mem_fill_data <= line;
                end
            end
        end
    end

    task automatic load_stimulus();
        int                 fd;
        int                 test_no;
        logic [7:0]         letter;
        cache_pkg::addr_t   addr;
        cache_pkg::byteen_t byteen;
        cache_pkg::word_t   wdata;
        cache_pkg::word_t   rdata;
        stim_t              entry;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file %s", STIM_FILE);
        end else begin
            while ($fscanf(fd, "%d %c %h %h %h %h", test_no, letter, addr, byteen, wdata,
                           rdata) == 6) begin
                if (letter != "R" && letter != "W") begin
                    errors++;
                    $display("Test %0d has an unknown operation letter", test_no);
                end
                entry.test_no = 16'(test_no);
                entry.write   = letter == "W";
                entry.addr    = addr;
                entry.byteen  = byteen;
                entry.wdata   = wdata;
                entry.rdata   = rdata;
                stim_q.push_back(entry);
            end
            $fclose(fd);
            if (stim_q.size() == 0) begin
                errors++;
                $display("The stimulus file holds no operations");
            end
        end
        loaded = 1'b1;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (core_busy && waited < IDLE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (core_busy) begin
            errors++;
            $display("core_busy stayed high for %0d cycles", IDLE_LIMIT);
        end
    endtask

    task automatic check_idle_after_reset();
        int errors_before;
        errors_before = errors;
        repeat (IDLE_CHECK_CYCLES) begin
            @(negedge clk);
            check_flag("core_busy", core_busy, 1'b0);
            check_flag("core_rsp", core_rsp, 1'b0);
            check_flag("mem_req", mem_req, 1'b0);
            check_flag("mem_wr", mem_wr, 1'b0);
        end
        tests++;
        $display("test reset: %s", errors == errors_before ? "pass" : "fail");
    endtask

    task automatic run_op(stim_t e);
        cache_pkg::core_req_t req;
        cache_pkg::mem_wr_t   exp_wr;
        int                   errors_before;
        int                   cycle;
        int                   last;
        bit                   hit;
        bit                   answered;
        errors_before = errors;
        hit           = 1'b0;
        answered      = 1'b0;
        wait_idle();
        if (!e.write) begin
            hit = predict_hit(e.addr);
        end
        req.write     = e.write;
        req.addr      = e.addr;
        req.byteen    = e.byteen;
        req.wdata     = e.wdata;
        exp_wr.addr   = e.addr;
        exp_wr.byteen = e.byteen;
        exp_wr.data   = e.wdata;
        @(posedge clk);
        core_req  <= 1'b1;
        core_data <= req;
        @(posedge clk);
        core_req  <= 1'b0;
        // Cycle 1 is the lookup cycle after the strobe
        last = e.write ? 3 : READ_LIMIT;
        for (cycle = 1; cycle <= last && !answered; cycle++) begin
            @(negedge clk);
            check_flag("mem_wr", mem_wr, e.write && cycle == 1);
            check_flag("mem_req", mem_req, !e.write && !hit && cycle == 2);
            check_flag("core_busy", core_busy, !e.write || cycle <= 2);
            if (mem_wr) begin
                check_wr("mem_wr_data", mem_wr_data, exp_wr);
            end
            if (mem_req) begin
                check_addr("mem_req_addr", mem_req_addr, e.addr & LINE_MASK);
            end
            if (core_rsp) begin
                answered = 1'b1;
                if (e.write) begin
                    errors++;
                    $display("Test %0d: a write produced a read response", e.test_no);
                end else begin
                    check_word("core_rsp_data", core_rsp_data, e.rdata);
                    if (hit ? cycle != 2 : cycle <= 2) begin
                        errors++;
                        $display("Test %0d: response after %0d cycles does not fit a %s",
                                 e.test_no, cycle, hit ? "hit" : "miss");
                    end
                end
            end
        end
        if (!e.write && !answered) begin
            errors++;
            $display("Test %0d: no read response within %0d cycles", e.test_no, READ_LIMIT);
        end
        tests++;
        $display("test %0d %s %h: %s", e.test_no,
                 e.write ? "write" : (hit ? "read hit" : "read miss"), e.addr,
                 errors == errors_before ? "pass" : "fail");
    endtask

    initial begin
        int limit;
        wait (loaded);
        limit = stim_q.size() * 40 + 200;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles with tests still running", limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n     <= 1'b0;
        core_req  <= 1'b0;
        core_data <= '0;
        load_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        check_idle_after_reset();
        foreach (stim_q[i]) begin
            run_op(stim_q[i]);
        end
        $display("tests=%0d errors=%0d", tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verif/cache_stimulus.txt
1 R 00000100 0 00000000 5a5a0100
2 R 00000108 0 00000000 5a5a0108
3 R 0000010c 0 00000000 5a5a010c
4 W 00000104 3 deadbeef 00000000
5 R 00000104 0 00000000 5a5abeef
6 W 00000204 c 12345678 00000000
7 R 00000204 0 00000000 12340204
8 R 00000100 0 00000000 5a5a0100
9 R 00001030 0 00000000 5a5a1030
10 R 00002034 0 00000000 5a5a2034
11 R 00003038 0 00000000 5a5a3038
12 R 00002038 0 00000000 5a5a2038
13 R 00001034 0 00000000 5a5a1034
14 R 00003030 0 00000000 5a5a3030
15 R a5c01040 0 00000000 ff9a1040
16 R a5c0104c 0 00000000 ff9a104c
17 W a5c01048 f 0badf00d 00000000
18 R a5c01048 0 00000000 0badf00d
19 W a5c01044 1 000000aa 00000000
20 R a5c01044 0 00000000 ff9a10aa
21 W 00000310 2 0000cd00 00000000
22 R 00000310 0 00000000 5a5acd10
23 R 00000314 0 00000000 5a5a0314
24 R 00000208 0 00000000 5a5a0208
25 R 00004030 0 00000000 5a5a4030
26 R 00001038 0 00000000 5a5a1038
27 R 0000303c 0 00000000 5a5a303c
28 W 00004034 9 11223344 00000000
29 R 00004034 0 00000000 115a4044
30 R 00000000 0 00000000 5a5a0000
31 R 00000200 0 00000000 5a5a0200
32 W 00000000 f cafef00d 00000000
33 R 00000000 0 00000000 cafef00d
34 R 00000104 0 00000000 5a5abeef
